//--- cmd_dispatch.sv
// ##############################
// Header decode and idle gate
// Unknown opcodes are consumed like a nop
// Stream headers of fewer than 4 bytes are dropped
// ##############################
`timescale 1ns/100ps
`include "raster_cmd_cfg.svh"

module cmd_dispatch
    import raster_cmd_pkg::*;
(
    input  logic         aclk,
    input  logic         resetn,
    input  logic         s_valid,
    input  cmd_header_u  s_data,
    input  logic         payload_ready,
    input  logic         job_done,
    input  logic         fb_busy,
    input  logic         rasterizer_running,
    input  logic         pixel_in_pipeline,
    output logic         s_ready,
    output logic         job_start,
    output stream_job_t  job,
    output logic         fb_start,
    output fb_op_t       fb_op,
    output logic         start_rendering
);
    // Byte size to beat count
    localparam int byte_shift = $clog2(`CMD_W / 8);

    typedef enum logic [1:0] {st_wait_idle, st_hdr_in, st_busy} state_e;

    state_e       state;
    logic         wait_fb;
    logic         hdr_ready;
    logic         hdr_take;
    logic         idle;
    stream_job_t  dec_job;
    fb_op_t       dec_fb;

    assign hdr_ready = (state == st_hdr_in);
    assign hdr_take  = s_valid && hdr_ready;
    assign s_ready   = hdr_ready || payload_ready;
    assign idle = !fb_busy && !pixel_in_pipeline && !rasterizer_running && !start_rendering;

    always_comb
    begin
        dec_job = '0;
        case (s_data.triangle.op)
            op_triangle_stream:
            begin
                dec_job.target = tgt_rasterizer;
                dec_job.beats  = s_data.triangle.size >> byte_shift;
            end
            op_texture_stream:
            begin
                dec_job.target = s_data.texture.tmu ? tgt_tmu1 : tgt_tmu0;
                dec_job.beats  = s_data.texture.size >> byte_shift;
            end
            op_fog_lut_stream:
            begin
                dec_job.target = tgt_fog;
                dec_job.beats  = `BEAT_CNT_W'(`FOG_LUT_BEATS);
            end
            op_render_config:
            begin
                dec_job.target = tgt_config;
                dec_job.beats  = `BEAT_CNT_W'(1);
                dec_job.user   = s_data.cfg.idx;
            end
            default:
                dec_job.target = tgt_none;
        endcase

        // Swap only concerns the color buffer
        dec_fb.commit        = s_data.fb.commit;
        dec_fb.memset        = s_data.fb.memset;
        dec_fb.swap          = s_data.fb.swap;
        dec_fb.apply_color   = s_data.fb.color_sel;
        dec_fb.apply_depth   = s_data.fb.depth_sel && !s_data.fb.swap;
        dec_fb.apply_stencil = s_data.fb.stencil_sel && !s_data.fb.swap;
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state           <= st_wait_idle;
            wait_fb         <= 1'b0;
            job_start       <= 1'b0;
            fb_start        <= 1'b0;
            start_rendering <= 1'b0;
        end
        else
        begin
            job_start <= 1'b0;
            fb_start  <= 1'b0;
            if (rasterizer_running)
                start_rendering <= 1'b0;
            case (state)
                st_wait_idle:
                begin
                    if (idle)
                        state <= st_hdr_in;
                end
                st_hdr_in:
                begin
                    if (s_valid)
                    begin
                        if (s_data.fb.op == op_framebuffer)
                        begin
                            fb_start <= 1'b1;
                            wait_fb  <= 1'b1;
                            state    <= st_busy;
                        end
                        else if (dec_job.target != tgt_none && dec_job.beats != '0)
                        begin
                            job_start <= 1'b1;
                            wait_fb   <= 1'b0;
                            state     <= st_busy;
                        end
                        else
                        begin
                            // Nop or empty stream
                            state <= st_wait_idle;
                        end
                    end
                end
                st_busy:
                begin
                    if (wait_fb ? !fb_busy : job_done)
                    begin
                        if (!wait_fb && job.target == tgt_rasterizer)
                            start_rendering <= 1'b1;
                        state <= st_wait_idle;
                    end
                end
                default:
                    state <= st_wait_idle;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (hdr_take)
        begin
            job   <= dec_job;
            fb_op <= dec_fb;
        end
    end

    // Router completion only arrives for an outstanding stream job
    a_done_expected: assert property (@(posedge aclk) disable iff (!resetn)
        job_done |-> (state == st_busy) && !wait_fb);

    // Header and payload phases never overlap on the shared ready
    a_ready_exclusive: assert property (@(posedge aclk) disable iff (!resetn)
        hdr_ready |-> !payload_ready);

endmodule

//--- fb_apply_ctrl.sv
// ##############################
// Framebuffer apply handshake
// Buffers drop applied when they take a command
// and raise it again once done
// ##############################
`timescale 1ns/100ps

module fb_apply_ctrl
    import raster_cmd_pkg::*;
(
    input  logic    aclk,
    input  logic    resetn,
    input  logic    fb_start,
    input  fb_op_t  fb_op,
    input  logic    color_applied,
    input  logic    depth_applied,
    input  logic    stencil_applied,
    output logic    color_apply,
    output logic    depth_apply,
    output logic    stencil_apply,
    output fb_op_t  buf_cmd,
    output logic    fb_busy
);
    typedef enum logic {fb_wait_drop, fb_wait_rise} fb_state_e;

    fb_state_e state;
    logic      any_apply;
    logic      all_applied;
    logic      busy_q;

    assign any_apply   = color_apply || depth_apply || stencil_apply;
    assign all_applied = color_applied && depth_applied && stencil_applied;
    assign busy_q      = any_apply || (state == fb_wait_rise);

    // Start counts as busy so the dispatcher never sees a gap
    assign fb_busy = fb_start || busy_q;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state         <= fb_wait_drop;
            color_apply   <= 1'b0;
            depth_apply   <= 1'b0;
            stencil_apply <= 1'b0;
        end
        else
        begin
            case (state)
                fb_wait_drop:
                begin
                    if (fb_start)
                    begin
                        color_apply   <= fb_op.apply_color;
                        depth_apply   <= fb_op.apply_depth;
                        stencil_apply <= fb_op.apply_stencil;
                    end
                    else if (any_apply && !all_applied)
                    begin
                        // Buffers have taken the command
                        color_apply   <= 1'b0;
                        depth_apply   <= 1'b0;
                        stencil_apply <= 1'b0;
                        state         <= fb_wait_rise;
                    end
                end
                fb_wait_rise:
                begin
                    if (all_applied)
                        state <= fb_wait_drop;
                end
                default:
                    state <= fb_wait_drop;
            endcase
        end
    end

    // Command flags stay steady until the next operation
    always_ff @(posedge aclk)
    begin
        if (fb_start)
            buf_cmd <= fb_op;
    end

    a_no_start_busy: assert property (@(posedge aclk) disable iff (!resetn)
        fb_start |-> !busy_q);

endmodule

//--- raster_cmd_cfg.svh
// ##############################
// Command front end build constants
// Only a 32-bit command stream is supported
// Opcode must sit in the top OP_W bits
// ##############################
`ifndef RASTER_CMD_CFG_SVH
`define RASTER_CMD_CFG_SVH

// Stream width and opcode field
`define CMD_W 32
`define OP_POS 28
`define OP_W 4

// Payload beat counter, wide enough for any byte size field
`define BEAT_CNT_W 19

// Fixed length of a fog table upload
`define FOG_LUT_BEATS 66

// Render config register index, also carried as beat user
`define CFG_IDX_W 5

// Number of payload targets
`define TGT_N 5

`endif

//--- raster_cmd_front.sv
// ##############################
// Rasterizer command front end
// 32-bit stream, one command at a time
// s_cmd_ready returning marks command end
// ##############################
`timescale 1ns/100ps
`include "raster_cmd_cfg.svh"

module raster_cmd_front
    import raster_cmd_pkg::*;
(
    input  logic               aclk,
    input  logic               resetn,

    // Command stream
    input  logic               s_cmd_valid,
    output logic               s_cmd_ready,
    input  logic [`CMD_W-1:0]  s_cmd_data,

    // Payload targets share one beat
    output stream_beat_t       m_cmd_beat,
    output logic               rasterizer_valid,
    input  logic               rasterizer_ready,
    output logic               tmu0_valid,
    input  logic               tmu0_ready,
    output logic               tmu1_valid,
    input  logic               tmu1_ready,
    output logic               fog_valid,
    input  logic               fog_ready,
    output logic               config_valid,
    input  logic               config_ready,

    // Buffer control
    output logic               color_apply,
    input  logic               color_applied,
    output logic               depth_apply,
    input  logic               depth_applied,
    output logic               stencil_apply,
    input  logic               stencil_applied,
    output fb_op_t             buf_cmd,

    // Rasterizer status
    input  logic               rasterizer_running,
    input  logic               pixel_in_pipeline,
    output logic               start_rendering
);
    logic               payload_ready;
    logic               job_start;
    stream_job_t        job;
    logic               job_done;
    logic               fb_start;
    fb_op_t             fb_op;
    logic               fb_busy;
    logic [`TGT_N-1:0]  tgt_ready;
    logic [`TGT_N-1:0]  tgt_valid;

    // Bit order follows cmd_target_e
    assign tgt_ready = {config_ready, fog_ready, tmu1_ready, tmu0_ready, rasterizer_ready};
    assign {config_valid, fog_valid, tmu1_valid, tmu0_valid, rasterizer_valid} = tgt_valid;

    cmd_dispatch dispatch_i (
        .aclk               (aclk),
        .resetn             (resetn),
        .s_valid            (s_cmd_valid),
        .s_data             (s_cmd_data),
        .payload_ready      (payload_ready),
        .job_done           (job_done),
        .fb_busy            (fb_busy),
        .rasterizer_running (rasterizer_running),
        .pixel_in_pipeline  (pixel_in_pipeline),
        .s_ready            (s_cmd_ready),
        .job_start          (job_start),
        .job                (job),
        .fb_start           (fb_start),
        .fb_op              (fb_op),
        .start_rendering    (start_rendering)
    );

    stream_router router_i (
        .aclk          (aclk),
        .resetn        (resetn),
        .job_start     (job_start),
        .job           (job),
        .s_valid       (s_cmd_valid),
        .s_data        (s_cmd_data),
        .tgt_ready     (tgt_ready),
        .payload_ready (payload_ready),
        .tgt_valid     (tgt_valid),
        .m_beat        (m_cmd_beat),
        .job_done      (job_done)
    );

    fb_apply_ctrl fb_ctrl_i (
        .aclk            (aclk),
        .resetn          (resetn),
        .fb_start        (fb_start),
        .fb_op           (fb_op),
        .color_applied   (color_applied),
        .depth_applied   (depth_applied),
        .stencil_applied (stencil_applied),
        .color_apply     (color_apply),
        .depth_apply     (depth_apply),
        .stencil_apply   (stencil_apply),
        .buf_cmd         (buf_cmd),
        .fb_busy         (fb_busy)
    );

endmodule

//--- raster_cmd_pkg.sv
// ##############################
// Types shared by RTL and testbench
// Every header view keeps the opcode in bits 31..28
// Target one-hot bit n belongs to target value n+1
// ##############################
`include "raster_cmd_cfg.svh"

package raster_cmd_pkg;

    typedef enum logic [`OP_W-1:0] {
        op_nop             = 4'd0,
        op_triangle_stream = 4'd1,
        op_texture_stream  = 4'd2,
        op_fog_lut_stream  = 4'd3,
        op_render_config   = 4'd4,
        op_framebuffer     = 4'd5
    } cmd_op_e;

    typedef enum logic [2:0] {
        tgt_none       = 3'd0,
        tgt_rasterizer = 3'd1,
        tgt_tmu0       = 3'd2,
        tgt_tmu1       = 3'd3,
        tgt_fog        = 3'd4,
        tgt_config     = 3'd5
    } cmd_target_e;

    // Header views, sizes are in bytes
    typedef struct packed {
        cmd_op_e                          op;
        logic [`OP_POS-`BEAT_CNT_W-1:0]   rsvd;
        logic [`BEAT_CNT_W-1:0]           size;
    } hdr_triangle_t;

    typedef struct packed {
        cmd_op_e                          op;
        logic [`OP_POS-`BEAT_CNT_W-2:0]   rsvd;
        logic                             tmu;
        logic [`BEAT_CNT_W-1:0]           size;
    } hdr_texture_t;

    typedef struct packed {
        cmd_op_e                          op;
        logic [`OP_POS-`CFG_IDX_W-1:0]    rsvd;
        logic [`CFG_IDX_W-1:0]            idx;
    } hdr_config_t;

    typedef struct packed {
        cmd_op_e                          op;
        logic [`OP_POS-7:0]               rsvd;
        logic                             commit;
        logic                             memset;
        logic                             swap;
        logic                             color_sel;
        logic                             depth_sel;
        logic                             stencil_sel;
    } hdr_fb_t;

    typedef union packed {
        hdr_triangle_t triangle;
        hdr_texture_t  texture;
        hdr_config_t   cfg;
        hdr_fb_t       fb;
    } cmd_header_u;

    // Apply flags already have the swap rule folded in
    typedef struct packed {
        logic commit;
        logic memset;
        logic swap;
        logic apply_color;
        logic apply_depth;
        logic apply_stencil;
    } fb_op_t;

    typedef struct packed {
        logic [`CMD_W-1:0]     data;
        logic [`CFG_IDX_W-1:0] user;
        logic                  last;
    } stream_beat_t;

    typedef struct packed {
        cmd_target_e            target;
        logic [`BEAT_CNT_W-1:0] beats;
        logic [`CFG_IDX_W-1:0]  user;
    } stream_job_t;

    function automatic logic [`TGT_N-1:0] tgt_onehot(cmd_target_e t);
        logic [`TGT_N-1:0] oh;
        oh = '0;
        if (t != tgt_none)
            oh[t - 3'd1] = 1'b1;
        return oh;
    endfunction

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the command front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_raster_cmd_front --Mdir obj_dir -o tb_raster_cmd_front > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/tb_raster_cmd_front > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status, see sim.log"
    exit 1
fi

if grep -qx "Simulation passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see sim.log"
exit 1

//--- stream_router.sv
// ##############################
// Payload router, one-entry output register
// Jobs must carry a non-zero beat count
// tgt_ready/tgt_valid bit n is target n+1
// ##############################
`timescale 1ns/100ps
`include "raster_cmd_cfg.svh"

module stream_router
    import raster_cmd_pkg::*;
(
    input  logic               aclk,
    input  logic               resetn,
    input  logic               job_start,
    input  stream_job_t        job,
    input  logic               s_valid,
    input  logic [`CMD_W-1:0]  s_data,
    input  logic [`TGT_N-1:0]  tgt_ready,
    output logic               payload_ready,
    output logic [`TGT_N-1:0]  tgt_valid,
    output stream_beat_t       m_beat,
    output logic               job_done
);
    localparam logic [`BEAT_CNT_W-1:0] one_beat = 1;

    logic                   active;
    logic [`BEAT_CNT_W-1:0] remaining;
    cmd_target_e            target;
    logic [`CFG_IDX_W-1:0]  user;
    logic                   out_valid;
    logic [`TGT_N-1:0]      sel;
    logic                   out_take;
    logic                   in_take;

    assign sel = tgt_onehot(target);
    assign tgt_valid = out_valid ? sel : '0;
    assign out_take = out_valid && |(tgt_ready & sel);

    // Accept while beats remain and the register frees up this cycle
    assign payload_ready = active && (remaining != '0) && (!out_valid || out_take);
    assign in_take = s_valid && payload_ready;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            active    <= 1'b0;
            remaining <= '0;
            target    <= tgt_none;
            out_valid <= 1'b0;
            job_done  <= 1'b0;
        end
        else
        begin
            job_done <= 1'b0;
            if (job_start)
            begin
                active    <= 1'b1;
                remaining <= job.beats;
                target    <= job.target;
            end
            if (in_take)
            begin
                out_valid <= 1'b1;
                remaining <= remaining - one_beat;
            end
            else if (out_take)
            begin
                out_valid <= 1'b0;
            end
            // Job ends when the target takes the final beat
            if (out_take && m_beat.last)
            begin
                active   <= 1'b0;
                job_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (job_start)
            user <= job.user;
        if (in_take)
        begin
            m_beat.data <= s_data;
            m_beat.user <= user;
            m_beat.last <= (remaining == one_beat);
        end
    end

    // Dispatcher waits for job_done and drops empty jobs
    a_job_start_idle: assert property (@(posedge aclk) disable iff (!resetn)
        job_start |-> !active && (job.beats != '0));

    // A held beat always names exactly one target
    a_one_valid: assert property (@(posedge aclk) disable iff (!resetn)
        out_valid |-> $onehot(tgt_valid));

endmodule

//--- tb_raster_cmd_front.sv
// ##############################
// Testbench for the command front end
// Target, buffer and rasterizer models are simple
// Stream sizes must be multiples of 4 bytes
// ##############################
`timescale 1ns/100ps
`include "raster_cmd_cfg.svh"

// Buffer that drops applied for a few cycles when it sees apply
module buffer_model #(
    parameter int hold = 3
) (
    input  logic aclk,
    input  logic resetn,
    input  logic apply,
    output logic applied
);
    initial
    begin
        applied = 1'b1;
        forever
        begin
            @(posedge aclk);
            #2;
            if (resetn && apply && applied)
            begin
                applied = 1'b0;
                repeat (hold) @(posedge aclk);
                #2;
                applied = 1'b1;
            end
        end
    end
endmodule

module tb_raster_cmd_front
    import raster_cmd_pkg::*;
;
    localparam int n_cmds = 14;

    logic aclk;
    logic resetn;
    logic s_cmd_valid;
    logic s_cmd_ready;
    logic [`CMD_W-1:0] s_cmd_data;
    stream_beat_t m_cmd_beat;
    logic [4:0] tgt_valid;
    logic [4:0] tgt_ready;
    logic color_apply, depth_apply, stencil_apply;
    logic color_applied, depth_applied, stencil_applied;
    fb_op_t buf_cmd;
    logic rasterizer_running;
    logic pixel_in_pipeline;
    logic start_rendering;

    logic [31:0] cmds [0:n_cmds-1];
    stream_beat_t exp_beats [$];
    cmd_target_e exp_tgts [$];
    integer seed = 88;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int cmd_no = 0;
    logic hdr_phase = 1'b0;
    logic seen_color, seen_depth, seen_stencil, seen_start, seen_running;

    raster_cmd_front dut_i (
        .aclk               (aclk),
        .resetn             (resetn),
        .s_cmd_valid        (s_cmd_valid),
        .s_cmd_ready        (s_cmd_ready),
        .s_cmd_data         (s_cmd_data),
        .m_cmd_beat         (m_cmd_beat),
        .rasterizer_valid   (tgt_valid[0]),
        .rasterizer_ready   (tgt_ready[0]),
        .tmu0_valid         (tgt_valid[1]),
        .tmu0_ready         (tgt_ready[1]),
        .tmu1_valid         (tgt_valid[2]),
        .tmu1_ready         (tgt_ready[2]),
        .fog_valid          (tgt_valid[3]),
        .fog_ready          (tgt_ready[3]),
        .config_valid       (tgt_valid[4]),
        .config_ready       (tgt_ready[4]),
        .color_apply        (color_apply),
        .color_applied      (color_applied),
        .depth_apply        (depth_apply),
        .depth_applied      (depth_applied),
        .stencil_apply      (stencil_apply),
        .stencil_applied    (stencil_applied),
        .buf_cmd            (buf_cmd),
        .rasterizer_running (rasterizer_running),
        .pixel_in_pipeline  (pixel_in_pipeline),
        .start_rendering    (start_rendering)
    );

    buffer_model #(.hold(2)) color_buf_i (aclk, resetn, color_apply, color_applied);
    buffer_model #(.hold(3)) depth_buf_i (aclk, resetn, depth_apply, depth_applied);
    buffer_model #(.hold(4)) stencil_buf_i (aclk, resetn, stencil_apply, stencil_applied);

    initial
    begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    // Target sinks, each ready high about three quarters of the time
    initial
    begin : target_sinks
        logic [31:0] rnd;
        tgt_ready = '0;
        forever
        begin
            @(posedge aclk);
            #2;
            rnd = $random(seed);
            tgt_ready = rnd[4:0] | rnd[9:5];
        end
    end

    // Rasterizer runs for a while, then pixels drain from the pipeline
    initial
    begin
        rasterizer_running = 1'b0;
        pixel_in_pipeline = 1'b0;
        forever
        begin
            @(posedge aclk);
            #2;
            if (resetn && start_rendering && !rasterizer_running)
            begin
                rasterizer_running = 1'b1;
                repeat (6) @(posedge aclk);
                #2;
                pixel_in_pipeline = 1'b1;
                rasterizer_running = 1'b0;
                repeat (4) @(posedge aclk);
                #2;
                pixel_in_pipeline = 1'b0;
            end
        end
    end

    function automatic logic [31:0] make_hdr(input logic [3:0] op, input logic [27:0] field);
        return {op, field};
    endfunction

    function automatic logic [31:0] payload_word(input int cmd, input int idx);
        return {8'(cmd), 8'hc3, 16'(idx)};
    endfunction

    // Expected job from the header fields, sizes in bytes
    function automatic stream_job_t ref_job(input logic [31:0] hdr);
        stream_job_t j;
        j = '0;
        case (hdr[31:28])
            4'd1:
            begin
                j.target = tgt_rasterizer;
                j.beats  = hdr[18:0] / 4;
            end
            4'd2:
            begin
                j.target = hdr[19] ? tgt_tmu1 : tgt_tmu0;
                j.beats  = hdr[18:0] / 4;
            end
            4'd3:
            begin
                j.target = tgt_fog;
                j.beats  = `FOG_LUT_BEATS;
            end
            4'd4:
            begin
                j.target = tgt_config;
                j.beats  = 1;
                j.user   = hdr[4:0];
            end
            default:
                j.target = tgt_none;
        endcase
        if (j.beats == 0)
            j.target = tgt_none;
        return j;
    endfunction

    function automatic stream_beat_t ref_beat(input stream_job_t j, input logic [31:0] d,
                                              input int idx);
        stream_beat_t b;
        b.data = d;
        b.user = j.user;
        b.last = (idx == int'(j.beats) - 1);
        return b;
    endfunction

    // Depth and stencil are blocked by swap
    function automatic fb_op_t ref_fb(input logic [31:0] hdr);
        fb_op_t f;
        f.commit        = hdr[5];
        f.memset        = hdr[4];
        f.swap          = hdr[3];
        f.apply_color   = hdr[2];
        f.apply_depth   = hdr[1] && !hdr[3];
        f.apply_stencil = hdr[0] && !hdr[3];
        return f;
    endfunction

    task automatic check_beat(input stream_beat_t got, input cmd_target_e got_tgt,
                              input stream_beat_t exp, input cmd_target_e exp_tgt);
        checks++;
        if (got !== exp || got_tgt !== exp_tgt)
        begin
            errors++;
            $display("Error at %0t ns: beat to %s data %h user %0d last %b, expected %s %h %0d %b",
                     $time, got_tgt.name(), got.data, got.user, got.last,
                     exp_tgt.name(), exp.data, exp.user, exp.last);
        end
    endtask

    task automatic check_fb(input fb_op_t got, input fb_op_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error at %0t ns: framebuffer op %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic send_word(input logic [31:0] d);
        logic done;
        done = 1'b0;
        s_cmd_valid = 1'b1;
        s_cmd_data = d;
        while (!done)
        begin
            @(negedge aclk);
            done = s_cmd_ready;
            @(posedge aclk);
            #2;
        end
    endtask

    // Ready coming back marks the end of a command
    task automatic wait_cmd_end();
        logic done;
        done = 1'b0;
        while (!done)
        begin
            @(negedge aclk);
            done = s_cmd_ready;
            @(posedge aclk);
            #2;
        end
    endtask

    task automatic run_command(input logic [31:0] hdr);
        stream_job_t job;
        fb_op_t got_fb;
        int i;
        job = ref_job(hdr);
        seen_color = 1'b0;
        seen_depth = 1'b0;
        seen_stencil = 1'b0;
        seen_start = 1'b0;
        seen_running = 1'b0;
        for (i = 0; i < int'(job.beats); i++)
        begin
            exp_beats.push_back(ref_beat(job, payload_word(cmd_no, i), i));
            exp_tgts.push_back(job.target);
        end
        hdr_phase = 1'b1;
        send_word(hdr);
        hdr_phase = 1'b0;
        for (i = 0; i < int'(job.beats); i++)
            send_word(payload_word(cmd_no, i));
        s_cmd_valid = 1'b0;
        wait_cmd_end();
        if (exp_beats.size() != 0)
        begin
            errors++;
            $display("Command %0d ended with %0d beats never delivered", cmd_no, exp_beats.size());
            exp_beats.delete();
            exp_tgts.delete();
        end
        if (hdr[31:28] == 4'd5)
        begin
            // Flags held for the buffers, then the levels actually driven
            check_fb(buf_cmd, ref_fb(hdr));
            got_fb = buf_cmd;
            got_fb.apply_color = seen_color;
            got_fb.apply_depth = seen_depth;
            got_fb.apply_stencil = seen_stencil;
            check_fb(got_fb, ref_fb(hdr));
        end
        else if (seen_color || seen_depth || seen_stencil)
        begin
            errors++;
            $display("Command %0d raised an apply level without a framebuffer op", cmd_no);
        end
        if (job.target == tgt_rasterizer && !(seen_start && seen_running))
        begin
            errors++;
            $display("Command %0d finished a triangle stream without starting the render", cmd_no);
        end
        else if (job.target != tgt_rasterizer && seen_start)
        begin
            errors++;
            $display("Command %0d started rendering without a triangle stream", cmd_no);
        end
        cmd_no++;
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("Test %0d %s: %s, %0d errors", tests, name,
                 (errors == err0) ? "ok" : "mismatch", errors - err0);
    endtask

    task automatic run_test(input string name, input int first, input int count);
        int err0;
        int i;
        err0 = errors;
        for (i = first; i < first + count; i++)
            run_command(cmds[i]);
        report_test(name, err0);
    endtask

    task automatic check_reset();
        int err0;
        err0 = errors;
        checks++;
        if (s_cmd_ready !== 1'b0 || tgt_valid !== 5'b0 || start_rendering !== 1'b0 ||
            {color_apply, depth_apply, stencil_apply} !== 3'b0)
        begin
            errors++;
            $display("Error at %0t ns: in reset ready %b valid %b apply %b start %b",
                     $time, s_cmd_ready, tgt_valid, {color_apply, depth_apply, stencil_apply},
                     start_rendering);
        end
        report_test("reset", err0);
    endtask

    // Compares every transfer and watches the idle gate
    always @(negedge aclk)
    begin : monitor
        cmd_target_e t;
        int k;
        if (resetn)
        begin
            seen_color   = seen_color | color_apply;
            seen_depth   = seen_depth | depth_apply;
            seen_stencil = seen_stencil | stencil_apply;
            seen_start   = seen_start | start_rendering;
            seen_running = seen_running | rasterizer_running;
            if ($countones(tgt_valid) > 1)
            begin
                errors++;
                $display("More than one target valid at %0t ns: %b", $time, tgt_valid);
            end
            else if ((tgt_valid & tgt_ready) != 5'b0)
            begin
                t = tgt_none;
                for (k = 0; k < 5; k++)
                    if (tgt_valid[k])
                        t = cmd_target_e'(k + 1);
                if (exp_beats.size() == 0)
                begin
                    errors++;
                    $display("Beat to %s at %0t ns when none was expected", t.name(), $time);
                end
                else
                    check_beat(m_cmd_beat, t, exp_beats.pop_front(), exp_tgts.pop_front());
            end
            if (s_cmd_ready && !(color_applied && depth_applied && stencil_applied))
            begin
                errors++;
                $display("Command ready at %0t ns while a buffer has not applied", $time);
            end
            if (hdr_phase && s_cmd_valid && s_cmd_ready &&
                (start_rendering || rasterizer_running || pixel_in_pipeline))
            begin
                errors++;
                $display("Header taken at %0t ns while the rasterizer was busy", $time);
            end
        end
    end

    // Cycle limit from the payload length of all commands
    initial
    begin : watchdog
        stream_job_t job;
        int limit;
        int cycles;
        int i;
        @(posedge aclk);
        limit = 0;
        for (i = 0; i < n_cmds; i++)
        begin
            job = ref_job(cmds[i]);
            limit = limit + int'(job.beats) * 4 + 200;
        end
        cycles = 0;
        while (cycles < limit)
        begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        resetn = 1'b0;
        s_cmd_valid = 1'b0;
        s_cmd_data = '0;
        cmds[0]  = make_hdr(4'd0, 28'd0);
        cmds[1]  = make_hdr(4'd1, 28'd40);
        cmds[2]  = make_hdr(4'd3, 28'd0);
        cmds[3]  = make_hdr(4'd4, 28'd17);
        cmds[4]  = make_hdr(4'd2, 28'd32);
        cmds[5]  = make_hdr(4'd2, 28'd0);
        cmds[6]  = make_hdr(4'd2, 28'h80018);
        cmds[7]  = make_hdr(4'd5, 28'b100111);
        cmds[8]  = make_hdr(4'd5, 28'b001111);
        cmds[9]  = make_hdr(4'd5, 28'b100000);
        cmds[10] = make_hdr(4'd5, 28'b010011);
        cmds[11] = make_hdr(4'd1, 28'd400);
        cmds[12] = make_hdr(4'd2, 28'h80100);
        cmds[13] = make_hdr(4'd4, 28'd3);
        repeat (7) @(posedge aclk);
        @(negedge aclk);
        check_reset();
        @(posedge aclk);
        #2;
        resetn = 1'b1;
        run_test("nop", 0, 1);
        run_test("triangle_fog_config", 1, 3);
        run_test("texture_select", 4, 3);
        run_test("framebuffer", 7, 4);
        run_test("backpressure", 11, 3);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
raster_cmd_pkg.sv
stream_router.sv
fb_apply_ctrl.sv
cmd_dispatch.sv
raster_cmd_front.sv
tb_raster_cmd_front.sv
